/* common/bp_cfg_pkg.sv */
package bp_cfg_pkg;

	// Width of every address in the front end.
	localparam int XLEN = 64;

	// Fetch is word aligned so the two low PC bits never carry information.
	localparam int PC_ALIGN_W = 2;

	// Both tables start their index right above the alignment bits.
	// The BTB tag follows the index, and the stored target bits sit above
	// the alignment bits as well. The upper target bits are borrowed
	// from the fetch PC when a target is rebuilt.

endpackage

/* common/bp_msg_pkg.sv */
package bp_msg_pkg;

	// One branch resolution coming back from the execute stage.
	typedef struct packed {
		logic                        valid;       // One-cycle strobe.
		logic                        is_cond;     // Conditional branch.
		logic                        taken;       // Resolved direction.
		logic                        mispredict;  // Fetch went down the wrong path.
		logic [bp_cfg_pkg::XLEN-1:0] pc;          // Branch PC.
		logic [bp_cfg_pkg::XLEN-1:0] target;      // Computed target.
	} br_resolve_t;

	// BTB answer for the current fetch PC.
	typedef struct packed {
		logic                        hit;         // PC is a known taken branch.
		logic                        is_cond;     // Entry came from a conditional branch.
		logic [bp_cfg_pkg::XLEN-1:0] target;      // Predicted target.
	} btb_lookup_t;

	// Two-bit saturating counter.
	// Upper bit set means predict taken.
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,                        // Saturated not taken.
		WEAK_NT   = 2'b01,                        // Reset state.
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11                         // Saturated taken.
	} ctr_state_e;

endpackage

/* btb/branch_target_buffer.sv */
`timescale 1ns/1ns

module branch_target_buffer #(
	parameter int BTB_SEL_W = 4,                      // Index width.
	parameter int BTB_TAG_W = 10,                     // Tag width.
	parameter int BTB_VAL_W = 12                      // Stored target bits.
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [bp_cfg_pkg::XLEN-1:0] fetch_pc_i,   // Current fetch PC.
	input  bp_msg_pkg::br_resolve_t     resolve_i,    // Execute-stage resolution.
	output bp_msg_pkg::btb_lookup_t     lookup_o      // Lookup for fetch_pc_i.
);

	localparam int BTB_NUM = 1 << BTB_SEL_W;          // Entry count.
	localparam int AL_W    = bp_cfg_pkg::PC_ALIGN_W;
	localparam int SEL_LO  = AL_W;                    // Index starts above alignment.
	localparam int SEL_HI  = AL_W + BTB_SEL_W - 1;
	localparam int TAG_LO  = SEL_HI + 1;              // Tag sits right above the index.
	localparam int TAG_HI  = TAG_LO + BTB_TAG_W - 1;
	localparam int VAL_HI  = AL_W + BTB_VAL_W - 1;    // Top of the stored target bits.

	logic [BTB_NUM-1:0]   valid_q;                    // Entry holds a taken branch.
	logic [BTB_TAG_W-1:0] tag_q  [BTB_NUM];
	logic [BTB_VAL_W-1:0] val_q  [BTB_NUM];           // Low target bits only.
	logic                 cond_q [BTB_NUM];

	logic [BTB_SEL_W-1:0] fetch_sel, res_sel;
	logic [BTB_TAG_W-1:0] fetch_tag, res_tag;
	logic [BTB_VAL_W-1:0] res_val;
	logic                 res_write;                  // Taken resolve updates an entry.
	logic                 bypass;                     // Resolve targets the fetched PC.

	bp_msg_pkg::btb_lookup_t table_lookup;            // Answer from stored state.

	assign fetch_sel = fetch_pc_i[SEL_HI:SEL_LO];
	assign fetch_tag = fetch_pc_i[TAG_HI:TAG_LO];

	assign res_sel = resolve_i.pc[SEL_HI:SEL_LO];
	assign res_tag = resolve_i.pc[TAG_HI:TAG_LO];
	assign res_val = resolve_i.target[VAL_HI:AL_W];   // Drop alignment and upper bits.

	assign res_write = resolve_i.valid && resolve_i.taken;
	assign bypass    = resolve_i.valid && (resolve_i.pc == fetch_pc_i);

	// Table read.
	always_comb begin
		table_lookup = '0;
		if (valid_q[fetch_sel] && (tag_q[fetch_sel] == fetch_tag)) begin
			table_lookup.hit     = 1'b1;
			table_lookup.is_cond = cond_q[fetch_sel];
			// Upper bits from fetch PC, low bits word aligned.
			table_lookup.target  = {fetch_pc_i[bp_cfg_pkg::XLEN-1:VAL_HI+1],
				val_q[fetch_sel], {AL_W{1'b0}}};
		end
	end

	// Same-cycle resolve of the fetched PC wins over the table.
	always_comb begin
		if (bypass) begin
			lookup_o = '0;                            // Not taken means no hit.
			if (resolve_i.taken) begin
				lookup_o.hit     = 1'b1;
				lookup_o.is_cond = resolve_i.is_cond;
				lookup_o.target  = resolve_i.target;  // Full target straight from EX.
			end
		end else begin
			lookup_o = table_lookup;
		end
	end

	// Valid bits clear at reset so PC zero cannot hit.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (res_write) begin
			valid_q[res_sel] <= 1'b1;
		end
	end

	// Entry payload.
	// A not-taken resolve leaves the entry as it is.
	always_ff @(posedge clk) begin
		if (res_write) begin
			tag_q[res_sel]  <= res_tag;               // Replaces any alias at this index.
			val_q[res_sel]  <= res_val;
			cond_q[res_sel] <= resolve_i.is_cond;
		end
	end

endmodule

/* dirp/direction_predictor.sv */
`timescale 1ns/1ns

module direction_predictor #(
	parameter int DIRP_SEL_W = 5                      // Counter index width.
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [bp_cfg_pkg::XLEN-1:0] fetch_pc_i,   // Current fetch PC.
	input  bp_msg_pkg::br_resolve_t     resolve_i,    // Execute-stage resolution.
	output logic                        pred_taken_o  // Counter says taken.
);

	localparam int DIRP_NUM = 1 << DIRP_SEL_W;        // Counter count.
	localparam int SEL_LO   = bp_cfg_pkg::PC_ALIGN_W; // Skip the alignment bits.
	localparam int SEL_HI   = SEL_LO + DIRP_SEL_W - 1;

	bp_msg_pkg::ctr_state_e ctr_q [DIRP_NUM];         // One counter per index.
	bp_msg_pkg::ctr_state_e fetch_ctr;                // Counter under the fetch PC.

	logic [DIRP_SEL_W-1:0] fetch_sel, res_sel;
	logic                  ctr_update;                // Conditional resolve arrived.

	// One saturating step toward the resolved direction.
	function automatic bp_msg_pkg::ctr_state_e ctr_next(
		input bp_msg_pkg::ctr_state_e cur,
		input logic                   taken
	);
		ctr_next = cur;                               // Strong states saturate.
		case (cur)
			bp_msg_pkg::STRONG_NT: begin
				if (taken) ctr_next = bp_msg_pkg::WEAK_NT;
			end
			bp_msg_pkg::WEAK_NT: begin
				if (taken) ctr_next = bp_msg_pkg::WEAK_T;
				else       ctr_next = bp_msg_pkg::STRONG_NT;
			end
			bp_msg_pkg::WEAK_T: begin
				if (taken) ctr_next = bp_msg_pkg::STRONG_T;
				else       ctr_next = bp_msg_pkg::WEAK_NT;
			end
			bp_msg_pkg::STRONG_T: begin
				if (!taken) ctr_next = bp_msg_pkg::WEAK_T;
			end
			default: ctr_next = bp_msg_pkg::WEAK_NT;
		endcase
	endfunction

	assign fetch_sel  = fetch_pc_i[SEL_HI:SEL_LO];
	assign res_sel    = resolve_i.pc[SEL_HI:SEL_LO];
	assign ctr_update = resolve_i.valid && resolve_i.is_cond; // Jumps leave counters alone.

	// No bypass here, so an update shows up one cycle later.
	assign fetch_ctr    = ctr_q[fetch_sel];
	assign pred_taken_o = (fetch_ctr == bp_msg_pkg::WEAK_T) ||
		(fetch_ctr == bp_msg_pkg::STRONG_T);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DIRP_NUM; i++) begin
				ctr_q[i] <= bp_msg_pkg::WEAK_NT;      // Lean not taken at start.
			end
		end else if (ctr_update) begin
			ctr_q[res_sel] <= ctr_next(ctr_q[res_sel], resolve_i.taken);
		end
	end

endmodule

/* source/fetch_pc_gen.sv */
`timescale 1ns/1ns

module fetch_pc_gen #(
	parameter logic [bp_cfg_pkg::XLEN-1:0] RESET_PC = '0  // Fetch address after reset.
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall_i,      // Hold the fetch PC.
	input  bp_msg_pkg::br_resolve_t     resolve_i,    // Execute-stage resolution.
	input  bp_msg_pkg::btb_lookup_t     lookup_i,     // BTB answer for pc_o.
	input  logic                        dir_taken_i,  // Counter direction for pc_o.
	output logic [bp_cfg_pkg::XLEN-1:0] pc_o,         // Current fetch PC.
	output logic                        pred_taken_o, // Fetch predicts a taken branch.
	output logic [bp_cfg_pkg::XLEN-1:0] next_pc_o     // PC for the next fetch.
);

	localparam int XLEN = bp_cfg_pkg::XLEN;
	localparam int AL_W = bp_cfg_pkg::PC_ALIGN_W;

	// One instruction word in bytes.
	localparam logic [XLEN-1:0] STEP = {{(XLEN-AL_W-1){1'b0}}, 1'b1, {AL_W{1'b0}}};

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] seq_pc;                          // Fall-through fetch.
	logic [XLEN-1:0] fix_pc;                          // Corrected path after mispredict.
	logic            redirect;                        // Execute stage overrides fetch.
	logic            pc_load;

	assign pc_o     = pc_q;
	assign seq_pc   = pc_q + STEP;
	assign redirect = resolve_i.valid && resolve_i.mispredict;

	// Resolved direction picks target or the word after the branch.
	assign fix_pc = resolve_i.taken ? resolve_i.target : (resolve_i.pc + STEP);

	// Jumps always go, conditionals ask the counter.
	assign pred_taken_o = lookup_i.hit && (!lookup_i.is_cond || dir_taken_i);

	always_comb begin
		if (redirect) begin
			next_pc_o = fix_pc;
		end else if (pred_taken_o) begin
			next_pc_o = lookup_i.target;
		end else begin
			next_pc_o = seq_pc;
		end
	end

	// A redirect gets through even while fetch is stalled.
	assign pc_load = redirect || !stall_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= RESET_PC;
		end else if (pc_load) begin
			pc_q <= next_pc_o;
		end
	end

endmodule

/* source/branch_predictor_top.sv */
`timescale 1ns/1ns

module branch_predictor_top #(
	parameter int                          BTB_SEL_W  = 4,   // BTB index width.
	parameter int                          BTB_TAG_W  = 10,  // BTB tag width.
	parameter int                          BTB_VAL_W  = 12,  // Stored target bits.
	parameter int                          DIRP_SEL_W = 5,   // Counter index width.
	parameter logic [bp_cfg_pkg::XLEN-1:0] RESET_PC   = '0   // Fetch address after reset.
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        stall_i,      // Fetch stall level.
	input  bp_msg_pkg::br_resolve_t     resolve_i,    // Execute-stage resolution.
	output logic [bp_cfg_pkg::XLEN-1:0] pc_o,         // Current fetch PC.
	output logic                        pred_taken_o, // Taken prediction for pc_o.
	output logic [bp_cfg_pkg::XLEN-1:0] next_pc_o     // Next fetch PC.
);

	bp_msg_pkg::btb_lookup_t btb_lookup;              // BTB to PC generator.
	logic                    dir_taken;               // Counter to PC generator.

	// Both tables look up the live fetch PC.
	branch_target_buffer #(
		.BTB_SEL_W (BTB_SEL_W),
		.BTB_TAG_W (BTB_TAG_W),
		.BTB_VAL_W (BTB_VAL_W)
	) u_btb (
		.clk        (clk),
		.rst        (rst),
		.fetch_pc_i (pc_o),
		.resolve_i  (resolve_i),
		.lookup_o   (btb_lookup)
	);

	direction_predictor #(
		.DIRP_SEL_W (DIRP_SEL_W)
	) u_dirp (
		.clk          (clk),
		.rst          (rst),
		.fetch_pc_i   (pc_o),
		.resolve_i    (resolve_i),
		.pred_taken_o (dir_taken)
	);

	fetch_pc_gen #(
		.RESET_PC (RESET_PC)
	) u_pc_gen (
		.clk          (clk),
		.rst          (rst),
		.stall_i      (stall_i),
		.resolve_i    (resolve_i),
		.lookup_i     (btb_lookup),
		.dir_taken_i  (dir_taken),
		.pc_o         (pc_o),
		.pred_taken_o (pred_taken_o),
		.next_pc_o    (next_pc_o)
	);

endmodule

/* verif/branch_predictor_assertions.sv */
`timescale 1ns/1ns

module branch_predictor_assertions (
	input logic                        clk,
	input logic                        rst,
	input logic [bp_cfg_pkg::XLEN-1:0] pc_i,          // Fetch PC.
	input logic                        pred_taken_i,
	input bp_msg_pkg::btb_lookup_t     btb_lookup_i,  // BTB answer inside the top.
	input bp_msg_pkg::br_resolve_t     resolve_i
);

	logic                        redirect;
	logic [bp_cfg_pkg::XLEN-1:0] fix_pc;              // Where a redirect must land.

	assign redirect = resolve_i.valid && resolve_i.mispredict;
	assign fix_pc   = resolve_i.taken ? resolve_i.target : (resolve_i.pc + 64'd4);

	pc_aligned: assert property (@(posedge clk) disable iff (rst)
		pc_i[bp_cfg_pkg::PC_ALIGN_W-1:0] == '0)
		else $error("Fetch PC %h is not word aligned.", pc_i);

	// No prediction without a BTB entry.
	pred_needs_hit: assert property (@(posedge clk) disable iff (rst)
		pred_taken_i |-> btb_lookup_i.hit)
		else $error("Taken prediction without a BTB hit at PC %h.", pc_i);

	redirect_lands: assert property (@(posedge clk) disable iff (rst)
		redirect |=> (pc_i == $past(fix_pc)))
		else $error("Redirect missed, fetch PC is %h.", pc_i);

endmodule

bind branch_predictor_top branch_predictor_assertions u_assertions (
	.clk          (clk),
	.rst          (rst),
	.pc_i         (pc_o),
	.pred_taken_i (pred_taken_o),
	.btb_lookup_i (btb_lookup),
	.resolve_i    (resolve_i)
);

/* verif/branch_predictor_tb.sv */
`timescale 1ns/1ns

module branch_predictor_tb;

	localparam int XLEN         = bp_cfg_pkg::XLEN;
	localparam int AL_W         = bp_cfg_pkg::PC_ALIGN_W;
	localparam int BTB_SEL_W    = 4;
	localparam int BTB_TAG_W    = 10;
	localparam int BTB_VAL_W    = 12;
	localparam int DIRP_SEL_W   = 5;
	localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_0000_1000;
	localparam logic [XLEN-1:0] WORD     = 64'd4;          // One instruction.
	localparam int HALF_PERIOD  = 50;                      // 100 ns clock.
	localparam int CHECK_DELAY  = 25;                      // Outputs settled by then.
	localparam int RESET_CYCLES = 8;
	localparam int RST_TIMEOUT  = 20;
	localparam int FILL_STEPS   = 40;

	// One row of the stimulus table.
	typedef struct packed {
		logic                    stall;
		bp_msg_pkg::br_resolve_t res;
		logic [XLEN-1:0]         exp_pc;
		logic                    exp_pred;
		logic [XLEN-1:0]         exp_next;
	} step_t;

	logic                    clk = 1'b0;                  // Low before any edge is counted.
	logic                    rst;
	logic                    stall_i;
	bp_msg_pkg::br_resolve_t resolve_i;
	logic [XLEN-1:0]         pc_o;
	logic                    pred_taken_o;
	logic [XLEN-1:0]         next_pc_o;

	step_t  steps[$];
	integer seed;
	int     err_cnt;

	// Reference model state.
	logic                 m_valid [1 << BTB_SEL_W];
	logic [BTB_TAG_W-1:0] m_tag   [1 << BTB_SEL_W];
	logic [BTB_VAL_W-1:0] m_val   [1 << BTB_SEL_W];  // Low target bits only.
	logic                 m_cond  [1 << BTB_SEL_W];
	logic [1:0]           m_ctr   [1 << DIRP_SEL_W]; // 0 strong NT up to 3 strong T.
	logic [XLEN-1:0]      m_pc;

	branch_predictor_top #(
		.BTB_SEL_W  (BTB_SEL_W),
		.BTB_TAG_W  (BTB_TAG_W),
		.BTB_VAL_W  (BTB_VAL_W),
		.DIRP_SEL_W (DIRP_SEL_W),
		.RESET_PC   (RESET_PC)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.stall_i      (stall_i),
		.resolve_i    (resolve_i),
		.pc_o         (pc_o),
		.pred_taken_o (pred_taken_o),
		.next_pc_o    (next_pc_o)
	);

	always #(HALF_PERIOD) clk = ~clk;

	function automatic logic [BTB_SEL_W-1:0] btb_index(input logic [XLEN-1:0] pc);
		return pc[AL_W +: BTB_SEL_W];                    // Right above alignment.
	endfunction

	function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [XLEN-1:0] pc);
		return pc[AL_W + BTB_SEL_W +: BTB_TAG_W];
	endfunction

	function automatic logic [DIRP_SEL_W-1:0] ctr_index(input logic [XLEN-1:0] pc);
		return pc[AL_W +: DIRP_SEL_W];
	endfunction

	// Upper bits follow the fetch PC, low bits are zero.
	function automatic logic [XLEN-1:0] rebuild_target(input logic [XLEN-1:0] pc,
		input logic [BTB_VAL_W-1:0] val);
		logic [XLEN-1:0] t;
		t = pc;
		t[AL_W +: BTB_VAL_W] = val;
		t[AL_W-1:0] = '0;
		return t;
	endfunction

	function automatic bp_msg_pkg::br_resolve_t make_res(input logic is_cond,
		input logic taken, input logic mispredict, input logic [XLEN-1:0] pc,
		input logic [XLEN-1:0] target);
		bp_msg_pkg::br_resolve_t r;
		r.valid      = 1'b1;
		r.is_cond    = is_cond;
		r.taken      = taken;
		r.mispredict = mispredict;
		r.pc         = pc;
		r.target     = target;
		return r;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < (1 << BTB_SEL_W); i++) begin
			m_valid[i] = 1'b0;                           // Nothing hits after reset.
			m_tag[i]   = '0;
			m_val[i]   = '0;
			m_cond[i]  = 1'b0;
		end
		for (int i = 0; i < (1 << DIRP_SEL_W); i++) begin
			m_ctr[i] = 2'd1;                             // Weakly not taken.
		end
		m_pc = RESET_PC;
	endtask

	// Expected outputs for one cycle, then the model takes the clock edge.
	task automatic add_step(input logic stall_v, input bp_msg_pkg::br_resolve_t res);
		step_t                 st;
		logic [BTB_SEL_W-1:0]  bi;
		logic [DIRP_SEL_W-1:0] ci;
		logic                  hit;
		logic                  cond;
		logic                  redir;
		logic [XLEN-1:0]       tgt;
		logic [XLEN-1:0]       nxt;
		hit  = 1'b0;
		cond = 1'b0;
		tgt  = '0;
		bi   = btb_index(m_pc);
		if (res.valid && (res.pc == m_pc)) begin
			hit  = res.taken;                            // Resolve decides this lookup.
			cond = res.is_cond;
			tgt  = res.target;
		end else if (m_valid[bi] && (m_tag[bi] == btb_tag(m_pc))) begin
			hit  = 1'b1;
			cond = m_cond[bi];
			tgt  = rebuild_target(m_pc, m_val[bi]);
		end
		st.exp_pred = hit && (!cond || m_ctr[ctr_index(m_pc)][1]);
		redir = res.valid && res.mispredict;
		if (redir) begin
			nxt = res.taken ? res.target : (res.pc + WORD);
		end else if (st.exp_pred) begin
			nxt = tgt;
		end else begin
			nxt = m_pc + WORD;
		end
		st.stall    = stall_v;
		st.res      = res;
		st.exp_pc   = m_pc;
		st.exp_next = nxt;
		steps.push_back(st);
		if (res.valid && res.taken) begin
			bi         = btb_index(res.pc);
			m_valid[bi] = 1'b1;
			m_tag[bi]   = btb_tag(res.pc);
			m_val[bi]   = res.target[AL_W +: BTB_VAL_W];
			m_cond[bi]  = res.is_cond;
		end
		if (res.valid && res.is_cond) begin
			ci = ctr_index(res.pc);
			if (res.taken && (m_ctr[ci] != 2'd3)) begin
				m_ctr[ci] = m_ctr[ci] + 2'd1;
			end else if (!res.taken && (m_ctr[ci] != 2'd0)) begin
				m_ctr[ci] = m_ctr[ci] - 2'd1;
			end
		end
		if (redir || !stall_v) begin
			m_pc = nxt;
		end
	endtask

	task automatic build_table();
		logic [XLEN-1:0]         p;
		logic [31:0]             rnd;
		bp_msg_pkg::br_resolve_t r;
		reset_model();
		for (int i = 0; i < 3; i++) begin
			add_step(1'b0, '0);                          // Plain sequential fetch.
		end
		add_step(1'b1, '0);
		add_step(1'b1, '0);                              // PC holds.
		add_step(1'b0, '0);
		// Jump learned off-path, then fetch is steered back onto it.
		// Its tag has both low bits set, yet the rebuilt target stays aligned.
		add_step(1'b0, make_res(1'b0, 1'b1, 1'b1, 64'h11c0, 64'h1400));
		add_step(1'b0, make_res(1'b0, 1'b0, 1'b1, 64'h11bc, 64'h0));
		add_step(1'b0, '0);                              // Jump predicted here.
		add_step(1'b0, '0);
		// Bypass on the fetched PC.
		p = m_pc;
		add_step(1'b1, make_res(1'b0, 1'b1, 1'b0, p, 64'h1800));
		add_step(1'b1, make_res(1'b0, 1'b0, 1'b0, p, 64'h1800));
		add_step(1'b1, '0);                              // Entry survived the not-taken.
		add_step(1'b0, '0);
		// Conditional branch walks its counter.
		p = m_pc;
		add_step(1'b1, make_res(1'b1, 1'b1, 1'b0, p, 64'h1c00));
		add_step(1'b1, '0);
		add_step(1'b1, make_res(1'b1, 1'b1, 1'b0, p, 64'h1c00));
		add_step(1'b1, make_res(1'b1, 1'b0, 1'b0, p, 64'h1c00));
		add_step(1'b1, '0);
		add_step(1'b1, make_res(1'b1, 1'b0, 1'b0, p, 64'h1c00));
		add_step(1'b1, '0);
		add_step(1'b0, '0);
		// Alias with the same index and another tag evicts the entry.
		p = m_pc;
		add_step(1'b1, make_res(1'b0, 1'b1, 1'b0, p, 64'h2000));
		add_step(1'b1, '0);
		add_step(1'b1, make_res(1'b0, 1'b1, 1'b0, p + 64'h40, 64'h2400));
		add_step(1'b1, '0);
		add_step(1'b0, '0);
		// Redirects get through a stall.
		add_step(1'b1, make_res(1'b0, 1'b1, 1'b1, 64'h2800, 64'h0000_0040_0000_2c00));
		add_step(1'b1, '0);
		add_step(1'b1, make_res(1'b1, 1'b0, 1'b1, 64'h3000, 64'h3800));
		add_step(1'b1, '0);
		for (int i = 0; i < FILL_STEPS; i++) begin
			rnd          = $random(seed);
			r            = '0;                           // Never valid.
			r.taken      = rnd[1];
			r.mispredict = rnd[2];
			r.pc         = {32'h0, $random(seed)};
			r.target     = {32'h0, $random(seed)};
			add_step(rnd[0], r);
		end
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while ((rst !== 1'b0) && (n < RST_TIMEOUT)) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			$display("Reset was still high after %0d cycles.", RST_TIMEOUT);
			$display("RESULT: FAIL");
			$fatal(1, "Reset wait timed out.");
		end
	endtask

	initial begin
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
	end

	initial begin
		rst       = 1'b1;
		stall_i   = 1'b1;                              // Keeps PC at reset value on release.
		resolve_i = '0;
		seed      = 32'hcf852ac7;
		err_cnt   = 0;
		build_table();
		wait_reset_release();
		for (int i = 0; i < steps.size(); i++) begin
			@(negedge clk);
			stall_i   = steps[i].stall;
			resolve_i = steps[i].res;
			#(CHECK_DELAY);
			check_value("pc_o", pc_o, steps[i].exp_pc);
			check_value("pred_taken_o", 64'(pred_taken_o), 64'(steps[i].exp_pred));
			check_value("next_pc_o", next_pc_o, steps[i].exp_next);
		end
		@(negedge clk);
		resolve_i = '0;
		stall_i   = 1'b1;
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "%0d checks failed.", err_cnt);
		end
	end

endmodule

/* branch_predictor_top.f */
common/bp_cfg_pkg.sv
common/bp_msg_pkg.sv
btb/branch_target_buffer.sv
dirp/direction_predictor.sv
source/fetch_pc_gen.sv
source/branch_predictor_top.sv
verif/branch_predictor_assertions.sv
verif/branch_predictor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the branch predictor testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

TOP=branch_predictor_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ns \
	--top-module "$TOP" \
	--Mdir "$OBJ_DIR" \
	-f branch_predictor_top.f

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "RESULT: PASS" "$LOG"; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed, see $LOG."
	exit 1
fi
